// ==== prog_decode.sv ====
module prog_decode (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        downloading,
    input  rom_pkg::dl_addr_t           ioctl_addr,
    input  rom_pkg::rom_byte_t          ioctl_dout,
    input  logic                        ioctl_wr,
    input  logic                        sdram_ack,
    output rom_pkg::sdram_addr_t        prog_addr,
    output rom_pkg::rom_byte_t          prog_data,
    output logic [1:0]                  prog_mask,
    output logic                        prog_we,
    output logic [rom_pkg::PROM_AW-1:0] prom_addr,
    output logic [rom_pkg::PROM_DW-1:0] prom_data,
    output logic                        prom_we
);
    import rom_pkg::*;

    logic        wr_ok;
    logic        is_prom;
    logic        is_obj;
    dl_addr_t    region_start;
    dl_addr_t    rel_addr;
    sdram_addr_t base_addr;

    assign wr_ok   = downloading && ioctl_wr;   // Stray strobes are dropped
    assign is_prom = ioctl_addr >= dl_addr_t'(PROM_START);
    assign is_obj  = !is_prom && (ioctl_addr >= dl_addr_t'(OBJ_START));

    // Objects get relocated, everything else maps straight
    assign region_start = is_obj ? dl_addr_t'(OBJ_START) : dl_addr_t'(MAIN_START);
    assign base_addr    = is_obj ? OBJ_SDRAM : MAIN_OFFSET;
    assign rel_addr     = ioctl_addr - region_start;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_ok && is_prom;   // Single pulse
            if (wr_ok && !is_prom)
                prog_we <= 1'b1;
            else if (sdram_ack)
                prog_we <= 1'b0;   // Held until SDRAM takes it
        end
    end

    // Write payload
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            prog_addr <= base_addr + rel_addr[22:1];
            prog_data <= ioctl_dout;
            // Even byte goes low, the mask covers the half left alone
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prom_addr <= ioctl_addr[PROM_AW-1:0];
            prom_data <= ioctl_dout[PROM_DW-1:0];
        end
    end

    // PROM bytes stay out of the SDRAM
    a_we_excl: assert property (@(posedge clk) disable iff (!rst_n)
        prom_we |-> !prog_we);

endmodule

// ==== rom_fetch.f ====
rom_pkg.sv
prog_decode.sv
rom_slot.sv
slot_arbiter.sv
rom_fetch.sv
tb_rom_fetch.sv

// ==== rom_fetch.sv ====
module rom_fetch (
    input  logic                        clk,
    input  logic                        rst_n,
    // Download stream
    input  logic                        downloading,
    input  rom_pkg::dl_addr_t           ioctl_addr,
    input  rom_pkg::rom_byte_t          ioctl_dout,
    input  logic                        ioctl_wr,
    output rom_pkg::sdram_addr_t        prog_addr,
    output rom_pkg::rom_byte_t          prog_data,
    output logic [1:0]                  prog_mask,
    output logic                        prog_we,
    output logic [rom_pkg::PROM_AW-1:0] prom_addr,
    output logic [rom_pkg::PROM_DW-1:0] prom_data,
    output logic                        prom_we,
    // SDRAM
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    input  rom_pkg::sdram_word_t        data_read,
    output logic                        sdram_req,
    output rom_pkg::sdram_addr_t        sdram_addr,
    // ROM clients
    input  logic                        main_cs,
    input  logic [rom_pkg::MAIN_AW-1:0] main_addr,
    output rom_pkg::rom_byte_t          main_data,
    output logic                        main_ok,
    input  logic                        snd_cs,
    input  logic [rom_pkg::SND_AW-1:0]  snd_addr,
    output rom_pkg::rom_byte_t          snd_data,
    output logic                        snd_ok,
    input  logic                        char_cs,
    input  logic [rom_pkg::CHAR_AW-1:0] char_addr,
    output rom_pkg::rom_byte_t          char_data,
    output logic                        char_ok,
    input  logic                        obj_cs,
    input  logic [rom_pkg::OBJ_AW-1:0]  obj_addr,
    output rom_pkg::rom_half_t          obj_data,
    output logic                        obj_ok
);
    import rom_pkg::*;

    // Slot order sets priority: main, sound, char, obj
    logic [SLOT_COUNT-1:0] slot_req;
    logic [SLOT_COUNT-1:0] slot_fill;
    sdram_addr_t           slot_addr [SLOT_COUNT];
    sdram_word_t           fill_data;

    prog_decode u_decode (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_dout  ( ioctl_dout  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_addr   ( prom_addr   ),
        .prom_data   ( prom_data   ),
        .prom_we     ( prom_we     )
    );

    slot_arbiter u_arbiter (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .req         ( slot_req    ),
        .word_addr   ( slot_addr   ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .fill        ( slot_fill   ),
        .fill_data   ( fill_data   ),
        .sdram_req   ( sdram_req   ),
        .sdram_addr  ( sdram_addr  )
    );

    rom_slot #(.payload_t(rom_byte_t), .AW(MAIN_AW), .OFFSET(MAIN_OFFSET)) u_main_slot (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .cs        ( main_cs      ),
        .addr      ( main_addr    ),
        .fill      ( slot_fill[0] ),
        .fill_data ( fill_data    ),
        .data      ( main_data    ),
        .ok        ( main_ok      ),
        .req       ( slot_req[0]  ),
        .word_addr ( slot_addr[0] )
    );

    rom_slot #(.payload_t(rom_byte_t), .AW(SND_AW), .OFFSET(SND_OFFSET)) u_snd_slot (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .cs        ( snd_cs       ),
        .addr      ( snd_addr     ),
        .fill      ( slot_fill[1] ),
        .fill_data ( fill_data    ),
        .data      ( snd_data     ),
        .ok        ( snd_ok       ),
        .req       ( slot_req[1]  ),
        .word_addr ( slot_addr[1] )
    );

    rom_slot #(.payload_t(rom_byte_t), .AW(CHAR_AW), .OFFSET(CHAR_OFFSET)) u_char_slot (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .cs        ( char_cs      ),
        .addr      ( char_addr    ),
        .fill      ( slot_fill[2] ),
        .fill_data ( fill_data    ),
        .data      ( char_data    ),
        .ok        ( char_ok      ),
        .req       ( slot_req[2]  ),
        .word_addr ( slot_addr[2] )
    );

    // Objects read half-words from the relocated area
    rom_slot #(.payload_t(rom_half_t), .AW(OBJ_AW), .OFFSET(OBJ_OFFSET)) u_obj_slot (
        .clk       ( clk          ),
        .rst_n     ( rst_n        ),
        .cs        ( obj_cs       ),
        .addr      ( obj_addr     ),
        .fill      ( slot_fill[3] ),
        .fill_data ( fill_data    ),
        .data      ( obj_data     ),
        .ok        ( obj_ok       ),
        .req       ( slot_req[3]  ),
        .word_addr ( slot_addr[3] )
    );

endmodule

// ==== rom_fetch_golden.txt ====
// Columns: command _ slot _ address _ data, all hex
// 1 download byte, 2 expected PROM write, 3 read, 4 read issued with next line,
// 5 read inside the cached word, F end. Slots: 0 main, 1 sound, 2 char, 3 obj
1_0_0000010_003C
1_0_0000011_00A5
1_0_0000025_007E
1_0_0028123_005A
1_0_0080456_00C3
1_0_00D0204_0011
1_0_00D0205_0022
1_0_00D0206_0033
1_0_00D0207_0044
1_0_019003A_00B7
2_0_000003A_0007
1_0_01900FF_000C
2_0_00000FF_000C
1_0_01A0001_005F
2_0_0000001_000F
3_0_0000011_00A5
5_0_0000010_003C
3_1_0000123_005A
3_2_0000456_00C3
4_0_0000025_007E
3_3_0000103_4433
5_3_0000102_2211
F_0_0000000_0000

// ==== rom_pkg.sv ====
package rom_pkg;

    // Bus and payload types
    typedef logic [21:0] sdram_addr_t;   // 16-bit word units
    typedef logic [31:0] sdram_word_t;   // One read beat, two words
    typedef logic [24:0] dl_addr_t;      // Byte address of the download stream
    typedef logic [ 7:0] rom_byte_t;
    typedef logic [15:0] rom_half_t;

    // Region starts inside the download stream
    localparam sdram_addr_t MAIN_START = 22'h00000;
    localparam sdram_addr_t SND_START  = 22'h28000;
    localparam sdram_addr_t CHAR_START = 22'h80000;
    localparam sdram_addr_t OBJ_START  = 22'hD0000;
    localparam sdram_addr_t PROM_START = 22'h190000;   // Priority PROM, not SDRAM

    // Object data is moved up to here
    localparam sdram_addr_t OBJ_SDRAM  = 22'h80000;

    // Slot base addresses in SDRAM
    localparam sdram_addr_t MAIN_OFFSET = 22'h0;
    localparam sdram_addr_t SND_OFFSET  = SND_START >> 1;
    localparam sdram_addr_t CHAR_OFFSET = CHAR_START >> 1;
    localparam sdram_addr_t OBJ_OFFSET  = OBJ_SDRAM;

    // Client address widths
    localparam int MAIN_AW = 18;   // Bytes
    localparam int SND_AW  = 15;
    localparam int CHAR_AW = 16;
    localparam int OBJ_AW  = 19;   // Half-words

    localparam int SLOT_COUNT = 4;
    localparam int SLOT_SEL_W = $clog2(SLOT_COUNT);

    // Priority PROM
    localparam int PROM_AW = 8;
    localparam int PROM_DW = 4;

endpackage

// ==== rom_slot.sv ====
module rom_slot #(
    parameter type                  payload_t = rom_pkg::rom_byte_t,
    parameter int                   AW        = 8,
    parameter rom_pkg::sdram_addr_t OFFSET    = '0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cs,
    input  logic [AW-1:0]        addr,
    input  logic                 fill,
    input  rom_pkg::sdram_word_t fill_data,
    output payload_t             data,
    output logic                 ok,
    output logic                 req,
    output rom_pkg::sdram_addr_t word_addr
);
    import rom_pkg::*;

    localparam int PW = $bits(payload_t);
    localparam int SW = $clog2($bits(sdram_word_t) / PW);   // Select bits inside a word
    localparam int TW = AW - SW;

    logic          valid;
    logic [TW-1:0] tag;
    logic [TW-1:0] req_tag;   // Tag being fetched
    sdram_word_t   cache;
    logic [TW-1:0] addr_tag;
    logic [SW-1:0] sel;
    logic          hit;
    logic          miss;

    assign addr_tag = addr[AW-1:SW];
    assign sel      = addr[SW-1:0];
    assign hit      = valid && (tag == addr_tag);
    assign miss     = cs && !hit && !req;

    assign ok   = cs && hit;
    assign data = cache[sel*PW +: PW];   // Lower address in lower bits

    // One beat covers two 16-bit words, so fetches start on an even word
    assign word_addr = OFFSET + sdram_addr_t'({req_tag, 1'b0});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else if (fill) begin
            valid <= 1'b1;
            req   <= 1'b0;
        end else if (miss) begin
            req <= 1'b1;
        end
    end

    // Cached word and tags
    always_ff @(posedge clk) begin
        if (miss)
            req_tag <= addr_tag;
        if (fill) begin
            tag   <= req_tag;
            cache <= fill_data;
        end
    end

    // The arbiter only fills a slot that is waiting
    a_fill_req: assert property (@(posedge clk) disable iff (!rst_n)
        fill |-> req);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the rom_fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rom_fetch.f --top-module tb_rom_fetch -o sim_rom_fetch
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_rom_fetch > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== slot_arbiter.sv ====
module slot_arbiter (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           downloading,
    input  logic [rom_pkg::SLOT_COUNT-1:0] req,
    input  rom_pkg::sdram_addr_t           word_addr [rom_pkg::SLOT_COUNT],
    input  logic                           sdram_ack,
    input  logic                           data_rdy,
    input  rom_pkg::sdram_word_t           data_read,
    output logic [rom_pkg::SLOT_COUNT-1:0] fill,
    output rom_pkg::sdram_word_t           fill_data,
    output logic                           sdram_req,
    output rom_pkg::sdram_addr_t           sdram_addr
);
    import rom_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_t;

    state_t                state;
    logic [SLOT_SEL_W-1:0] winner;
    logic [SLOT_SEL_W-1:0] pick;
    logic                  start;

    // Lowest index wins
    always_comb begin
        pick = '0;
        for (int i = SLOT_COUNT - 1; i >= 0; i--) begin
            if (req[i])
                pick = SLOT_SEL_W'(i);
        end
    end

    assign start = (state == IDLE) && !downloading && (|req);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= IDLE;
            sdram_req <= 1'b0;
            fill      <= '0;
        end else begin
            fill <= '0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state     <= WAIT_ACK;
                        sdram_req <= 1'b1;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        state     <= WAIT_DATA;
                        sdram_req <= 1'b0;
                    end
                end
                WAIT_DATA: begin
                    // Wait out the fill cycle so the slot can drop req
                    if (|fill)
                        state <= IDLE;
                    else if (data_rdy)
                        fill[winner] <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Winner, its address and the returned beat
    always_ff @(posedge clk) begin
        if (start) begin
            winner     <= pick;
            sdram_addr <= word_addr[pick];
        end
        if (state == WAIT_DATA && data_rdy && !(|fill))
            fill_data <= data_read;
    end

    // No read is launched from a download cycle
    a_no_dl_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sdram_req) |-> $past(!downloading));

endmodule

// ==== tb_rom_fetch.sv ====
module tb_rom_fetch;
    import rom_pkg::*;

    localparam int GOLDEN_DEPTH    = 64;
    localparam int CYCLES_PER_LINE = 200;

    logic               clk;
    logic               rst_n;
    logic               downloading;
    dl_addr_t           ioctl_addr;
    rom_byte_t          ioctl_dout;
    logic               ioctl_wr;
    sdram_addr_t        prog_addr;
    rom_byte_t          prog_data;
    logic [1:0]         prog_mask;
    logic               prog_we;
    logic [PROM_AW-1:0] prom_addr;
    logic [PROM_DW-1:0] prom_data;
    logic               prom_we;
    logic               sdram_ack;
    logic               data_rdy;
    sdram_word_t        data_read;
    logic               sdram_req;
    sdram_addr_t        sdram_addr;
    logic               main_cs;
    logic [MAIN_AW-1:0] main_addr;
    rom_byte_t          main_data;
    logic               main_ok;
    logic               snd_cs;
    logic [SND_AW-1:0]  snd_addr;
    rom_byte_t          snd_data;
    logic               snd_ok;
    logic               char_cs;
    logic [CHAR_AW-1:0] char_addr;
    rom_byte_t          char_data;
    logic               char_ok;
    logic               obj_cs;
    logic [OBJ_AW-1:0]  obj_addr;
    rom_half_t          obj_data;
    logic               obj_ok;

    logic [51:0]        golden [GOLDEN_DEPTH];   // {cmd, slot, address, data}
    logic [15:0]        sdram_mem [int];         // Sparse map keyed by word address
    int                 errors = 0;
    int                 tests = 0;
    int                 cur_line = 0;
    int                 cycle_count = 0;
    int                 watchdog_limit = CYCLES_PER_LINE;
    logic               saw_prog;
    logic               saw_prom;
    logic [PROM_AW-1:0] got_prom_addr;
    logic [PROM_DW-1:0] got_prom_data;
    int                 wr_cnt = 0;
    logic               wr_done = 1'b0;
    logic [15:0]        wr_word;
    int                 rd_state = 0;    // 0 idle, 1 ack pending, 2 data pending
    int                 rd_cnt = 0;
    sdram_addr_t        rd_addr;

    rom_fetch u_rom_fetch (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= watchdog_limit) begin
            $display("Watchdog expired after %0d cycles, DUT stuck at golden line %0d",
                     watchdog_limit, cur_line);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [15:0] read_word(input sdram_addr_t a);
        if (sdram_mem.exists(int'(a)))
            return sdram_mem[int'(a)];
        return a[15:0] ^ {10'h000, a[21:16]};   // Unwritten words follow the address
    endfunction

    // SDRAM model
    initial begin
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            #2;
            sdram_ack = 1'b0;
            data_rdy  = 1'b0;
            if (wr_cnt != 0) begin
                wr_cnt--;
                sdram_ack = (wr_cnt == 0);
            end else if (prog_we && !wr_done) begin
                wr_word = read_word(prog_addr);
                if (!prog_mask[0])
                    wr_word[7:0] = prog_data;
                if (!prog_mask[1])
                    wr_word[15:8] = prog_data;
                sdram_mem[int'(prog_addr)] = wr_word;
                wr_done = 1'b1;
                wr_cnt  = 2;
            end
            if (!prog_we)
                wr_done = 1'b0;
            // Reads get the ack after 2 cycles and the data 3 cycles later
            if (rd_state == 0 && sdram_req) begin
                rd_addr  = sdram_addr;
                rd_cnt   = 2;
                rd_state = 1;
            end else if (rd_state != 0) begin
                rd_cnt--;
                if (rd_cnt == 0 && rd_state == 1) begin
                    sdram_ack = 1'b1;
                    rd_cnt    = 3;
                    rd_state  = 2;
                end else if (rd_cnt == 0) begin
                    data_rdy  = 1'b1;
                    data_read = {read_word(rd_addr + 22'd1), read_word(rd_addr)};
                    rd_state  = 0;
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic download_byte(input dl_addr_t a, input rom_byte_t d);
        next_cycle();
        downloading = 1'b1;
        ioctl_addr  = a;
        ioctl_dout  = d;
        ioctl_wr    = 1'b1;
        next_cycle();
        ioctl_wr = 1'b0;
        saw_prog = 1'b0;
        saw_prom = 1'b0;
        // Next byte waits for the SDRAM ack or the PROM strobe
        while (!saw_prom && !(saw_prog && !prog_we)) begin
            @(negedge clk);
            if (prog_we)
                saw_prog = 1'b1;
            if (prom_we) begin
                saw_prom      = 1'b1;
                got_prom_addr = prom_addr;
                got_prom_data = prom_data;
            end
        end
        repeat (2) begin
            @(negedge clk);
            if (prog_we)
                saw_prog = 1'b1;
        end
    endtask

    task automatic select_slot(input logic [3:0] slot, input logic [27:0] a);
        case (slot)
            4'd0: begin
                main_cs   = 1'b1;
                main_addr = a[MAIN_AW-1:0];
            end
            4'd1: begin
                snd_cs   = 1'b1;
                snd_addr = a[SND_AW-1:0];
            end
            4'd2: begin
                char_cs   = 1'b1;
                char_addr = a[CHAR_AW-1:0];
            end
            default: begin
                obj_cs   = 1'b1;
                obj_addr = a[OBJ_AW-1:0];
            end
        endcase
    endtask

    function automatic logic slot_ok(input logic [3:0] slot);
        case (slot)
            4'd0: return main_ok;
            4'd1: return snd_ok;
            4'd2: return char_ok;
            default: return obj_ok;
        endcase
    endfunction

    function automatic logic [15:0] slot_data(input logic [3:0] slot);
        case (slot)
            4'd0: return {8'h00, main_data};
            4'd1: return {8'h00, snd_data};
            4'd2: return {8'h00, char_data};
            default: return obj_data;
        endcase
    endfunction

    // Miss read that may run together with a second client
    task automatic run_read(input logic [51:0] g, input logic pair, input logic [51:0] first);
        next_cycle();
        downloading = 1'b0;
        main_cs     = 1'b0;
        snd_cs      = 1'b0;
        char_cs     = 1'b0;
        obj_cs      = 1'b0;
        repeat ($urandom_range(3, 0)) next_cycle();
        if (pair)
            select_slot(first[47:44], first[43:16]);
        select_slot(g[47:44], g[43:16]);
        @(negedge clk);
        while (!(slot_ok(g[47:44]) && (!pair || slot_ok(first[47:44]))))
            @(negedge clk);
        if (pair)
            check_value("paired read data", 32'(slot_data(first[47:44])), 32'(first[15:0]));
        check_value("read data", 32'(slot_data(g[47:44])), 32'(g[15:0]));
    endtask

    task automatic cached_read(input logic [51:0] g);
        next_cycle();
        select_slot(g[47:44], g[43:16]);
        repeat (3) begin
            @(negedge clk);
            check_value("ok on cached read", 32'(slot_ok(g[47:44])), 32'd1);
            check_value("cached read data", 32'(slot_data(g[47:44])), 32'(g[15:0]));
            check_value("sdram_req on cached read", 32'(sdram_req), 32'd0);
        end
    endtask

    function automatic string command_name(input logic [3:0] cmd, input logic pair);
        case (cmd)
            4'h1: return "download byte";
            4'h2: return "PROM write";
            4'h3: return pair ? "paired read" : "read";
            4'h5: return "cached read";
            default: return "unknown command";
        endcase
    endfunction

    initial begin
        logic [51:0] g;
        logic [51:0] pair_line;
        logic        pair_pending;
        int          line_count;
        int          errs_before;

        void'($urandom(32'h59f));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        snd_cs      = 1'b0;
        snd_addr    = '0;
        char_cs     = 1'b0;
        char_addr   = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        pair_line    = '0;
        pair_pending = 1'b0;
        for (int i = 0; i < GOLDEN_DEPTH; i++)
            golden[i] = {4'hF, 48'h0};
        $readmemh("rom_fetch_golden.txt", golden);
        line_count = 0;
        while (line_count < GOLDEN_DEPTH && golden[line_count][51:48] != 4'hF)
            line_count++;
        watchdog_limit = (line_count + 1) * CYCLES_PER_LINE;

        repeat (4) next_cycle();
        rst_n = 1'b1;
        @(negedge clk);
        check_value("sdram_req after reset", 32'(sdram_req), 32'd0);
        check_value("prog_we after reset", 32'(prog_we), 32'd0);
        check_value("prom_we after reset", 32'(prom_we), 32'd0);
        check_value("ok after reset", 32'({main_ok, snd_ok, char_ok, obj_ok}), 32'd0);
        $display("test 0, reset values: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < line_count; i++) begin
            cur_line    = i + 1;
            g           = golden[i];
            errs_before = errors;
            case (g[51:48])
                4'h1: download_byte(g[40:16], g[7:0]);
                4'h2: begin
                    check_value("PROM strobe seen", 32'(saw_prom), 32'd1);
                    check_value("SDRAM write for PROM byte", 32'(saw_prog), 32'd0);
                    check_value("prom_addr", 32'(got_prom_addr), 32'(g[23:16]));
                    check_value("prom_data", 32'(got_prom_data), 32'(g[3:0]));
                end
                4'h3: run_read(g, pair_pending, pair_line);
                4'h4: begin
                    pair_line    = g;
                    pair_pending = 1'b1;
                end
                4'h5: cached_read(g);
                default: begin
                    $display("Golden line %0d holds unknown command %0h", cur_line, g[51:48]);
                    errors++;
                end
            endcase
            if (g[51:48] != 4'h4) begin
                tests++;
                $display("test %0d, golden line %0d, %s: %s", tests, cur_line,
                         command_name(g[51:48], pair_pending),
                         (errors == errs_before) ? "ok" : "mismatch");
            end
            if (g[51:48] == 4'h3)
                pair_pending = 1'b0;
        end

        $display("tests run: %0d, failed checks: %0d", tests + 1, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule
